// File: project.f
src/fetch_pkg.sv
src/fetch_stage.sv
src/predecode_lane.sv
src/fetch_queue.sv
src/fetch_unit.sv
bench/fetch_props.sv
bench/fetch_tb.sv

// File: Makefile
# Verilator build and run of the fetch unit testbench

VERILATOR  ?= verilator
TOP        ?= fetch_tb
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION PASSED" $(LOG); then \
		echo "run ok"; \
	else \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

  localparam int lanes = 2;
  localparam int mem_words = 256;
  localparam int num_packets = 2000;
  localparam int cycle_limit = 20 * num_packets;
  localparam logic [31:0] block_mask = ~32'(4 * lanes - 1);
  localparam logic [31:0] sel_all = 32'((1 << (4 * lanes)) - 1);

  logic                     clock = 1'b0;
  logic                     reset;
  fetch_pkg::redirect_t     redirect;
  fetch_pkg::wb_req_t       wb_req;
  fetch_pkg::wb_rsp_t       wb_rsp = '0;
  logic                     out_valid;
  fetch_pkg::fetch_packet_t out_packet;
  logic                     out_ready;

  logic [31:0] mem [mem_words];
  logic [31:0] expected_pc;
  int          packet_count;
  int          cycle_count;
  int          stall_left;
  int          wait_left = 0;
  logic        pending = 1'b0;
  int          seed_value;

  fetch_unit dut0 (
    .clock      (clock),
    .reset      (reset),
    .redirect   (redirect),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .out_valid  (out_valid),
    .out_packet (out_packet),
    .out_ready  (out_ready)
  );

  always #50 clock = ~clock;

  // immediates straight from the RISC-V encoding
  function automatic logic [31:0] jal_imm(input logic [31:0] w);
    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  function automatic logic [31:0] branch_imm(input logic [31:0] w);
    return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  function automatic logic [31:0] encode_jal(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // fields holds rs2, rs1 and funct3
  function automatic logic [31:0] encode_branch(input logic [12:0] off, input logic [12:0] fields);
    return {off[12], off[10:5], fields, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] index);
    return mem[index & 32'(mem_words - 1)];
  endfunction

  function automatic logic [31:0] random_target();
    return 32'($urandom % mem_words) << 2;
  endfunction

  function automatic logic [31:0] redirect_target(input fetch_pkg::redirect_t r);
    if (r.trap) begin
      return r.mtvec;
    end else if (r.mret) begin
      return r.mepc;
    end else if (r.miss) begin
      return r.miss_addr;
    end
    return r.fence_npc;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error: %s is %h, expected %h", name, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic fill_memory();
    logic [31:0] w;
    int          off;
    for (int i = 0; i < mem_words; i++) begin
      w = $urandom;
      // keep filler out of the jal and branch opcodes
      if (w[6:0] == 7'b1101111 || w[6:0] == 7'b1100011) begin
        w[4] = ~w[4];
      end
      if ($urandom % 8 == 0) begin
        off = int'($urandom % 32 + 1) * 4;
        case ($urandom % 3)
          0: w = encode_jal(($urandom % 2 == 0) ? 21'(off) : 21'(-off), 5'($urandom));
          1: w = encode_branch(13'(-off), 13'($urandom));
          default: w = encode_branch(13'(off), 13'($urandom));
        endcase
      end
      mem[i] = w;
    end
  endtask

  task automatic check_packet();
    logic [31:0] pc;
    logic [31:0] lane_pc;
    logic [31:0] w;
    logic [31:0] target;
    logic [3:0]  valid;
    logic        taken;
    pc = expected_pc;
    target = '0;
    valid = '0;
    taken = 1'b0;
    check_value("out_packet.pc", out_packet.pc, pc);
    for (int i = 0; i < lanes; i++) begin
      lane_pc = pc + 32'(4 * i);
      // only words inside the aligned block are fetched
      if ((lane_pc & block_mask) == (pc & block_mask)) begin
        w = mem_word((pc >> 2) + 32'(i));
        check_value($sformatf("out_packet.words[%0d]", i), out_packet.words[i], w);
        if (!taken) begin
          valid[i] = 1'b1;
          if (w[6:0] == 7'b1101111) begin
            taken = 1'b1;
            target = lane_pc + jal_imm(w);
          end else if (w[6:0] == 7'b1100011 && w[31]) begin
            taken = 1'b1;
            target = lane_pc + branch_imm(w);
          end
        end
      end
    end
    check_value("out_packet.lane_valid", 32'(out_packet.lane_valid), 32'(valid));
    check_value("out_packet.taken", 32'(out_packet.taken), 32'(taken));
    if (taken) begin
      check_value("out_packet.target", out_packet.target, target);
    end
    expected_pc = taken ? target : (pc & block_mask) + 32'(4 * lanes);
  endtask

  task automatic drive_ready();
    if (stall_left > 0) begin
      out_ready = 1'b0;
      stall_left--;
    end else if ($urandom % 200 == 0) begin
      stall_left = int'($urandom % 40) + 20;
      out_ready = 1'b0;
    end else begin
      out_ready = ($urandom % 4) != 0;
    end
  endtask

  task automatic drive_redirect();
    fetch_pkg::redirect_t r;
    r = '0;
    if ($urandom % 40 == 0) begin
      // any mix of sources with priority picking the target
      {r.trap, r.mret, r.miss, r.fence} = 4'($urandom % 15 + 1);
      r.mtvec = random_target();
      r.mepc = random_target();
      r.miss_addr = random_target();
      r.fence_npc = random_target();
    end
    redirect = r;
  endtask

  // wishbone slave with 0 to 3 wait states
  always @(negedge clock) begin
    logic [31:0] base;
    base = wb_req.adr >> 2;
    if (wb_rsp.ack || !wb_req.cyc) begin
      wb_rsp.ack = 1'b0;
      pending = 1'b0;
    end
    if (wb_req.cyc && wb_req.stb && !pending) begin
      check_value("wb_req.sel", 32'(wb_req.sel), sel_all);
      check_value("wb_req.adr offset", wb_req.adr & ~block_mask, 32'h0);
      pending = 1'b1;
      wait_left = int'($urandom % 4);
    end
    if (pending) begin
      if (wait_left == 0) begin
        wb_rsp.dat = {$urandom, $urandom, $urandom, $urandom};
        for (int i = 0; i < lanes; i++) begin
          wb_rsp.dat[32*i +: 32] = mem_word(base + 32'(i));
        end
        wb_rsp.ack = 1'b1;
        pending = 1'b0;
      end else begin
        wait_left--;
      end
    end
  end

  always @(posedge clock) begin
    if (reset) begin
      cycle_count++;
      if (redirect.trap || redirect.mret || redirect.miss || redirect.fence) begin
        expected_pc = redirect_target(redirect);
      end else if (out_valid && out_ready) begin
        check_packet();
        packet_count++;
      end
      if (dut0.props0.failures != 0) begin
        $display("a bus or queue protocol assertion failed");
        $display("SIMULATION FAILED");
        $fatal(1, "assertion failure");
      end else if (packet_count >= num_packets) begin
        $display("SIMULATION PASSED");
        $finish;
      end else if (cycle_count >= cycle_limit) begin
        $display("timeout, %0d of %0d packets seen after %0d cycles",
                 packet_count, num_packets, cycle_count);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
      end
    end
  end

  initial begin
    seed_value = $urandom(66);
    reset = 1'b0;
    redirect = '0;
    out_ready = 1'b0;
    expected_pc = '0;
    packet_count = 0;
    cycle_count = 0;
    stall_left = 0;
    fill_memory();
    repeat (5) begin
      @(negedge clock);
      check_value("wb_req.cyc", 32'(wb_req.cyc), 32'h0);
      check_value("wb_req.stb", 32'(wb_req.stb), 32'h0);
      check_value("out_valid", 32'(out_valid), 32'h0);
    end
    reset = 1'b1;
    forever begin
      @(negedge clock);
      drive_ready();
      drive_redirect();
    end
  end

endmodule

// File: bench/fetch_props.sv
`timescale 1ns/1ps

module fetch_props (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::redirect_t  redirect,
  input  fetch_pkg::wb_req_t    wb_req,
  input  fetch_pkg::wb_rsp_t    wb_rsp,
  input  logic                  out_valid
);

  int   failures = 0;
  logic redirect_any;

  assign redirect_any = redirect.trap | redirect.mret | redirect.miss | redirect.fence;

  stb_with_cyc: assert property (@(posedge clock) disable iff (!reset)
    wb_req.stb |-> wb_req.cyc)
    else begin
      failures++;
      $error("stb high while cyc is low");
    end

  // classic cycle holds until the slave acks
  hold_until_ack: assert property (@(posedge clock) disable iff (!reset)
    wb_req.cyc && !wb_rsp.ack |=> wb_req.cyc && $stable(wb_req.adr))
    else begin
      failures++;
      $error("cyc dropped or adr moved before ack");
    end

  read_only: assert property (@(posedge clock) disable iff (!reset) !wb_req.we)
    else begin
      failures++;
      $error("we driven high");
    end

  no_output_on_redirect: assert property (@(posedge clock) disable iff (!reset)
    redirect_any |-> !out_valid)
    else begin
      failures++;
      $error("out_valid high in a redirect cycle");
    end

endmodule

bind fetch_unit fetch_props props0 (
  .clock     (clock),
  .reset     (reset),
  .redirect  (redirect),
  .wb_req    (wb_req),
  .wb_rsp    (wb_rsp),
  .out_valid (out_valid)
);

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
  parameter int FETCH_LANES = 2,
  parameter int QUEUE_DEPTH = 4,
  parameter logic [31:0] RESET_PC = '0
) (
  input  logic                            clock,
  input  logic                            reset,
  input  fetch_pkg::redirect_t            redirect,
  output fetch_pkg::wb_req_t              wb_req,
  input  fetch_pkg::wb_rsp_t              wb_rsp,
  output logic                            out_valid,
  output fetch_pkg::fetch_packet_t        out_packet,
  input  logic                            out_ready
);

  localparam logic [fetch_pkg::xlen-1:0] pc_step = 4 * FETCH_LANES;
  localparam logic [fetch_pkg::xlen-1:0] align_mask = ~(pc_step - 1);

  fetch_pkg::fetch_group_t     group;
  logic                        group_valid;
  logic                        flush;
  logic                        pred_taken;
  logic [fetch_pkg::xlen-1:0]  pred_target;
  logic                        full;
  fetch_pkg::lane_info_t       lanes [FETCH_LANES];

  fetch_stage #(
    .FETCH_LANES (FETCH_LANES),
    .RESET_PC    (RESET_PC)
  ) stage0 (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .wb_rsp      (wb_rsp),
    .pred_taken  (pred_taken),
    .pred_target (pred_target),
    .full        (full),
    .wb_req      (wb_req),
    .group       (group),
    .group_valid (group_valid),
    .flush       (flush)
  );

  for (genvar i = 0; i < FETCH_LANES; i++) begin : g_lane
    logic [fetch_pkg::xlen-1:0] lane_pc;
    logic                       lane_ok;

    assign lane_pc = group.pc + fetch_pkg::xlen'(4 * i);
    // a group entered mid-block has no words past the block end
    assign lane_ok = group_valid && ((lane_pc & align_mask) == (group.pc & align_mask));

    predecode_lane lane0 (
      .word       (group.words[i]),
      .pc         (lane_pc),
      .word_valid (lane_ok),
      .info       (lanes[i])
    );
  end

  fetch_queue #(
    .FETCH_LANES (FETCH_LANES),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) queue0 (
    .clock       (clock),
    .reset       (reset),
    .group       (group),
    .group_valid (group_valid),
    .lanes       (lanes),
    .flush       (flush),
    .out_ready   (out_ready),
    .out_valid   (out_valid),
    .out_packet  (out_packet),
    .pred_taken  (pred_taken),
    .pred_target (pred_target),
    .full        (full)
  );

endmodule

// File: src/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue #(
  parameter int FETCH_LANES = 2,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                            clock,
  input  logic                            reset,
  input  fetch_pkg::fetch_group_t         group,
  input  logic                            group_valid,
  input  fetch_pkg::lane_info_t           lanes [FETCH_LANES],
  input  logic                            flush,
  input  logic                            out_ready,
  output logic                            out_valid,
  output fetch_pkg::fetch_packet_t        out_packet,
  output logic                            pred_taken,
  output logic [fetch_pkg::xlen-1:0]      pred_target,
  output logic                            full
);

  localparam int ptr_w = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int cnt_w = $clog2(QUEUE_DEPTH + 1);

  fetch_pkg::fetch_packet_t        mem [QUEUE_DEPTH];
  logic [ptr_w-1:0]                wr_ptr;
  logic [ptr_w-1:0]                rd_ptr;
  logic [cnt_w-1:0]                count;
  logic [fetch_pkg::max_lanes-1:0] lane_valid;
  fetch_pkg::fetch_packet_t        packet;
  logic                            push;
  logic                            pop;

  // first taken lane wins, everything after it is dropped
  always_comb begin
    logic found;
    found = 1'b0;
    lane_valid = '0;
    pred_taken = 1'b0;
    pred_target = '0;
    for (int i = 0; i < FETCH_LANES; i++) begin
      if (!found) begin
        lane_valid[i] = lanes[i].valid;
        if (lanes[i].valid && lanes[i].taken) begin
          found = 1'b1;
          pred_taken = 1'b1;
          pred_target = lanes[i].target;
        end
      end
    end
  end

  always_comb begin
    packet = '0;
    packet.pc = group.pc;
    packet.words = group.words;
    packet.lane_valid = lane_valid;
    packet.taken = pred_taken;
    packet.target = pred_target;
  end

  assign push = group_valid && !flush;
  assign out_valid = (count != '0) && !flush;
  assign pop = out_valid && out_ready;
  assign out_packet = mem[rd_ptr];
  // counts the packet arriving this cycle so the next request always has a slot
  assign full = (count == cnt_w'(QUEUE_DEPTH)) || (push && count == cnt_w'(QUEUE_DEPTH - 1));

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= packet;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: src/predecode_lane.sv
`timescale 1ns/1ps

module predecode_lane (
  input  fetch_pkg::instr_word_t          word,
  input  logic [fetch_pkg::xlen-1:0]      pc,
  input  logic                            word_valid,
  output fetch_pkg::lane_info_t           info
);

  logic [6:0]                  opcode;
  logic                        is_jal;
  logic                        is_branch;
  logic [fetch_pkg::xlen-1:0]  j_imm;
  logic [fetch_pkg::xlen-1:0]  b_imm;
  logic [fetch_pkg::xlen-1:0]  imm;

  // opcode field is shared by both formats
  assign opcode = word.j_view.opcode;
  assign is_jal = (opcode == fetch_pkg::opcode_jal);
  assign is_branch = (opcode == fetch_pkg::opcode_branch);

  // 21-bit jal offset, sign bit is imm[20]
  assign j_imm = {
    {11{word.j_view.imm_20}},
    word.j_view.imm_20,
    word.j_view.imm_19_12,
    word.j_view.imm_11,
    word.j_view.imm_10_1,
    1'b0
  };

  // 13-bit branch offset, sign bit is imm[12]
  assign b_imm = {
    {19{word.b_view.imm_12}},
    word.b_view.imm_12,
    word.b_view.imm_11,
    word.b_view.imm_10_5,
    word.b_view.imm_4_1,
    1'b0
  };

  assign imm = is_jal ? j_imm : b_imm;

  always_comb begin
    info = '0;
    info.valid = word_valid;
    // jal always taken, branches only when they go backward
    info.taken = word_valid && (is_jal || (is_branch && b_imm[fetch_pkg::xlen-1]));
    info.target = pc + imm;
  end

endmodule

// File: src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
  parameter int FETCH_LANES = 2,
  parameter logic [31:0] RESET_PC = '0
) (
  input  logic                            clock,
  input  logic                            reset,
  input  fetch_pkg::redirect_t            redirect,
  input  fetch_pkg::wb_rsp_t              wb_rsp,
  input  logic                            pred_taken,
  input  logic [fetch_pkg::xlen-1:0]      pred_target,
  input  logic                            full,
  output fetch_pkg::wb_req_t              wb_req,
  output fetch_pkg::fetch_group_t         group,
  output logic                            group_valid,
  output logic                            flush
);

  localparam logic [fetch_pkg::xlen-1:0] pc_step = 4 * FETCH_LANES;
  localparam logic [fetch_pkg::xlen-1:0] align_mask = ~(pc_step - 1);
  localparam logic [4*fetch_pkg::max_lanes-1:0] sel_mask = {(4 * FETCH_LANES){1'b1}};

  localparam logic [1:0] state_idle      = 2'd0;
  localparam logic [1:0] state_busy      = 2'd1;
  localparam logic [1:0] state_discard   = 2'd2;
  localparam logic [1:0] state_wait_room = 2'd3;

  logic [1:0]                  state;
  logic [1:0]                  state_next;
  // fetch pc of the open bus cycle, or of the next one while the bus is idle
  logic [fetch_pkg::xlen-1:0]  req_pc;
  logic [fetch_pkg::xlen-1:0]  req_pc_next;
  // redirect target parked until the stale ack comes back
  logic [fetch_pkg::xlen-1:0]  hold_pc;
  logic [fetch_pkg::xlen-1:0]  hold_pc_next;
  logic                        redirect_any;
  logic [fetch_pkg::xlen-1:0]  redirect_pc;
  logic [fetch_pkg::xlen-1:0]  seq_pc;
  logic [fetch_pkg::xlen-1:0]  pred_pc;
  logic [fetch_pkg::xlen-1:0]  word_off;
  logic                        bus_open;

  // fixed priority: trap, mret, branch miss, fence
  always_comb begin
    redirect_any = redirect.trap | redirect.mret | redirect.miss | redirect.fence;
    if (redirect.trap) begin
      redirect_pc = redirect.mtvec;
    end else if (redirect.mret) begin
      redirect_pc = redirect.mepc;
    end else if (redirect.miss) begin
      redirect_pc = redirect.miss_addr;
    end else begin
      redirect_pc = redirect.fence_npc;
    end
  end

  assign flush = redirect_any;
  assign bus_open = (state == state_busy) || (state == state_discard);
  assign group_valid = (state == state_busy) && wb_rsp.ack && !redirect_any;

  // continue after the aligned block even if the group started mid-block
  assign seq_pc = (req_pc & align_mask) + pc_step;
  assign pred_pc = pred_taken ? pred_target : seq_pc;
  assign word_off = (req_pc - (req_pc & align_mask)) >> 2;

  always_comb begin
    wb_req = '0;
    wb_req.cyc = bus_open;
    wb_req.stb = bus_open;
    wb_req.we = 1'b0;
    wb_req.adr = req_pc & align_mask;
    wb_req.sel = sel_mask;
  end

  // shift so lane 0 holds the word at req_pc
  always_comb begin
    group = '0;
    group.pc = req_pc;
    for (int i = 0; i < FETCH_LANES; i++) begin
      if (i + word_off < FETCH_LANES) begin
        group.words[i] = wb_rsp.dat[fetch_pkg::xlen*(i+word_off) +: fetch_pkg::xlen];
      end
    end
  end

  always_comb begin
    state_next = state;
    req_pc_next = req_pc;
    hold_pc_next = hold_pc;
    case (state)
      state_idle: begin
        state_next = state_busy;
        req_pc_next = redirect_any ? redirect_pc : req_pc;
      end
      state_busy: begin
        if (wb_rsp.ack) begin
          if (redirect_any) begin
            req_pc_next = redirect_pc;
          end else if (full) begin
            state_next = state_wait_room;
            req_pc_next = pred_pc;
          end else begin
            req_pc_next = pred_pc;
          end
        end else if (redirect_any) begin
          // bus cycle cannot be aborted, so wait out the ack
          state_next = state_discard;
          hold_pc_next = redirect_pc;
        end
      end
      state_discard: begin
        if (wb_rsp.ack) begin
          state_next = state_busy;
          req_pc_next = redirect_any ? redirect_pc : hold_pc;
        end else if (redirect_any) begin
          hold_pc_next = redirect_pc;
        end
      end
      state_wait_room: begin
        // a redirect flushes the queue, so room is guaranteed
        if (redirect_any) begin
          state_next = state_busy;
          req_pc_next = redirect_pc;
        end else if (!full) begin
          state_next = state_busy;
        end
      end
      default: begin
        state_next = state_idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= state_idle;
      req_pc <= RESET_PC;
      hold_pc <= RESET_PC;
    end else begin
      state <= state_next;
      req_pc <= req_pc_next;
      hold_pc <= hold_pc_next;
    end
  end

endmodule

// File: src/fetch_pkg.sv
package fetch_pkg;

  localparam int xlen = 32;
  localparam int max_lanes = 4;

  localparam logic [6:0] opcode_jal = 7'b1101111;
  localparam logic [6:0] opcode_branch = 7'b1100011;

  // jal, imm[20|10:1|11|19:12] above rd
  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  // conditional branch, imm[12|10:5] and imm[4:1|11] split around the registers
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_type_t;

  typedef union packed {
    j_type_t j_view;
    b_type_t b_view;
  } instr_word_t;

  typedef struct packed {
    logic            trap;
    logic            mret;
    logic            miss;
    logic            fence;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] miss_addr;
    logic [xlen-1:0] fence_npc;
  } redirect_t;

  typedef struct packed {
    logic            valid;
    logic            taken;
    logic [xlen-1:0] target;
  } lane_info_t;

  typedef struct packed {
    logic [xlen-1:0]                pc;
    instr_word_t [max_lanes-1:0]    words;
  } fetch_group_t;

  typedef struct packed {
    logic [xlen-1:0]                pc;
    instr_word_t [max_lanes-1:0]    words;
    logic [max_lanes-1:0]           lane_valid;
    logic                           taken;
    logic [xlen-1:0]                target;
  } fetch_packet_t;

  // bus sized for the widest group, narrower configs use the low lanes
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [xlen-1:0]        adr;
    logic [4*max_lanes-1:0] sel;
  } wb_req_t;

  typedef struct packed {
    logic [xlen*max_lanes-1:0] dat;
    logic                      ack;
  } wb_rsp_t;

endpackage
